// ==== memStage_macros.svh ====
`ifndef MEMSTAGE_MACROS_SVH
`define MEMSTAGE_MACROS_SVH

// BEV set, EXL and IE clear
`define STATUS_RESET 32'h0040_0000

// exception entry points
`define VEC_BOOT   32'hbfc0_0380
`define VEC_NORMAL 32'h8000_0180

// cp0 register numbers
`define CP0_BADVADDR 5'd8
`define CP0_STATUS   5'd12
`define CP0_CAUSE    5'd13
`define CP0_EPC      5'd14

// unmapped segment bases
`define KSEG0_BASE 32'h8000_0000
`define KSEG1_BASE 32'ha000_0000

`endif

// ==== memStagePkg.sv ====
package memStagePkg;

    typedef logic [31:0] word_t;      // data or address word
    typedef logic [4:0]  regAddr_t;   // gpr or cp0 register number

    typedef enum logic [3:0] {
        opNone,
        opLb,
        opLbu,
        opLh,
        opLhu,
        opLw,
        opSb,
        opSh,
        opSw
    } memOp_t;

    typedef enum logic [1:0] {
        cp0None,
        cp0Mfc0,
        cp0Mtc0,
        cp0Eret
    } cp0Op_t;

    // values follow the Cause.ExcCode field
    typedef enum logic [4:0] {
        excInt  = 5'd0,
        excAdel = 5'd4,
        excAdes = 5'd5,
        excNone = 5'd31   // no exception, also used for ERET
    } excCode_t;

    typedef enum logic [1:0] {
        busIdle,
        busAddr,
        busResp
    } busState_t;

endpackage

// ==== memStageReg.sv ====
module memStageReg (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  flush,
    input  logic                  wr,
    input  memStagePkg::word_t    exeAluOut,
    input  memStagePkg::word_t    exeOutB,
    input  memStagePkg::word_t    exePc,
    input  memStagePkg::memOp_t   exeMemOp,
    input  memStagePkg::cp0Op_t   exeCp0Op,
    input  memStagePkg::regAddr_t exeCp0Rd,
    input  memStagePkg::regAddr_t exeDst,
    input  logic                  exeRegWr,
    output memStagePkg::word_t    memAluOut,
    output memStagePkg::word_t    memOutB,
    output memStagePkg::word_t    memPc,
    output memStagePkg::memOp_t   memMemOp,
    output memStagePkg::cp0Op_t   memCp0Op,
    output memStagePkg::regAddr_t memCp0Rd,
    output memStagePkg::regAddr_t memDst,
    output logic                  memRegWr
);
    import memStagePkg::*;

    // control fields, a flush turns the stage into a bubble
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memMemOp <= opNone;
            memCp0Op <= cp0None;
            memRegWr <= 1'b0;
        end else if (flush) begin
            memMemOp <= opNone;
            memCp0Op <= cp0None;
            memRegWr <= 1'b0;
        end else if (wr) begin
            memMemOp <= exeMemOp;
            memCp0Op <= exeCp0Op;
            memRegWr <= exeRegWr;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            memAluOut <= exeAluOut;
            memOutB   <= exeOutB;
            memPc     <= exePc;
            memCp0Rd  <= exeCp0Rd;
            memDst    <= exeDst;
        end
    end

    // flush beats a hold
    flushWins: assert property (@(posedge clk) disable iff (!arstN)
        flush |=> (memMemOp == opNone) && (memCp0Op == cp0None) && !memRegWr);

endmodule

// ==== byteLaneAlign.sv ====
module byteLaneAlign (
    input  memStagePkg::memOp_t memOp,
    input  logic [1:0]          addrLow,
    input  memStagePkg::word_t  storeData,
    input  memStagePkg::word_t  loadWord,
    output memStagePkg::word_t  wdata,
    output logic [3:0]          wstrb,
    output memStagePkg::word_t  loadData
);
    import memStagePkg::*;

    word_t shifted;   // addressed lane moved down to bit 0

    assign shifted = loadWord >> {addrLow, 3'b000};

    always_comb begin
        wdata = storeData;
        wstrb = 4'b0000;     // loads and non-memory ops write nothing
        case (memOp)
            opSb: begin
                wdata = {4{storeData[7:0]}};
                wstrb = 4'b0001 << addrLow;
            end
            opSh: begin
                wdata = {2{storeData[15:0]}};
                wstrb = addrLow[1] ? 4'b1100 : 4'b0011;
            end
            opSw: wstrb = 4'b1111;
            default: ;
        endcase
    end

    always_comb begin
        case (memOp)
            opLb:    loadData = {{24{shifted[7]}}, shifted[7:0]};
            opLbu:   loadData = {24'b0, shifted[7:0]};
            opLh:    loadData = {{16{shifted[15]}}, shifted[15:0]};
            opLhu:   loadData = {16'b0, shifted[15:0]};
            default: loadData = loadWord;
        endcase
    end

endmodule

// ==== addrMap.sv ====
`include "memStage_macros.svh"

module addrMap (
    input  memStagePkg::word_t  vaddr,
    input  memStagePkg::memOp_t memOp,
    output memStagePkg::word_t  physAddr,
    output logic                addrErr
);
    import memStagePkg::*;

    localparam word_t kseg0Base = `KSEG0_BASE;
    localparam word_t kseg1Base = `KSEG1_BASE;

    logic unmapped;   // kseg0 or kseg1

    assign unmapped = (vaddr[31:29] == kseg0Base[31:29]) ||
                      (vaddr[31:29] == kseg1Base[31:29]);
    assign physAddr = unmapped ? {3'b000, vaddr[28:0]} : vaddr;   // useg and kseg2 as is

    always_comb begin
        case (memOp)
            opLh, opLhu, opSh: addrErr = vaddr[0];
            opLw, opSw:        addrErr = |vaddr[1:0];
            default:           addrErr = 1'b0;
        endcase
    end

endmodule

// ==== cp0Regs.sv ====
`include "memStage_macros.svh"

module cp0Regs (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [5:0]            interrupt,
    input  memStagePkg::cp0Op_t   cp0Op,
    input  memStagePkg::regAddr_t rdSel,
    input  memStagePkg::word_t    wdata,
    input  logic                  commit,
    input  logic                  excTake,
    input  memStagePkg::excCode_t excCode,
    input  memStagePkg::word_t    excPc,
    input  memStagePkg::word_t    badVAddr,
    output memStagePkg::word_t    rdata,
    output logic                  statusIe,
    output logic                  statusExl,
    output logic                  statusBev,
    output logic [7:0]            statusIm,
    output logic [7:0]            causeIp,
    output memStagePkg::word_t    epc
);
    import memStagePkg::*;

    localparam word_t statusMask = 32'h0040_ff03;   // BEV, IM, EXL, IE

    word_t      status;
    word_t      badVAddrReg;
    logic [5:0] ipHw;       // Cause[15:10]
    logic [1:0] ipSw;       // Cause[9:8]
    excCode_t   causeExc;
    logic       excWr;
    logic       eretWr;
    logic       mtc0Wr;

    assign excWr  = excTake && (excCode != excNone);
    assign eretWr = excTake && (excCode == excNone) && (cp0Op == cp0Eret);
    assign mtc0Wr = commit && (cp0Op == cp0Mtc0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            status   <= `STATUS_RESET;
            ipHw     <= '0;
            ipSw     <= '0;
            causeExc <= excInt;
        end else begin
            ipHw <= interrupt;   // sampled every cycle
            if (excWr) begin
                status[1] <= 1'b1;
                causeExc  <= excCode;
            end else if (eretWr) begin
                status[1] <= 1'b0;
            end else if (mtc0Wr) begin
                if (rdSel == `CP0_STATUS)
                    status <= wdata & statusMask;
                if (rdSel == `CP0_CAUSE)
                    ipSw <= wdata[9:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excWr)
            epc <= excPc;
        else if (mtc0Wr && (rdSel == `CP0_EPC))
            epc <= wdata;
        if (excWr && (excCode == excAdel || excCode == excAdes))
            badVAddrReg <= badVAddr;
    end

    assign statusIe  = status[0];
    assign statusExl = status[1];
    assign statusBev = status[22];
    assign statusIm  = status[15:8];
    assign causeIp   = {ipHw, ipSw};

    always_comb begin
        case (rdSel)
            `CP0_STATUS:   rdata = status;
            `CP0_CAUSE:    rdata = {16'b0, causeIp, 1'b0, causeExc, 2'b00};
            `CP0_EPC:      rdata = epc;
            `CP0_BADVADDR: rdata = badVAddrReg;
            default:       rdata = '0;
        endcase
    end

    // the top keeps mtc0 from committing under an exception
    noMtc0OnExc: assert property (@(posedge clk) disable iff (!arstN)
        !(mtc0Wr && excTake));

endmodule

// ==== exceptionUnit.sv ====
`include "memStage_macros.svh"

module exceptionUnit (
    input  memStagePkg::word_t    memPc,
    input  logic                  addrErr,
    input  memStagePkg::memOp_t   memMemOp,
    input  memStagePkg::cp0Op_t   memCp0Op,
    input  logic                  statusIe,
    input  logic                  statusExl,
    input  logic                  statusBev,
    input  logic [7:0]            statusIm,
    input  logic [7:0]            causeIp,
    input  memStagePkg::word_t    epc,
    output logic                  flushException,
    output memStagePkg::excCode_t excCode,
    output memStagePkg::word_t    exceptionVector
);
    import memStagePkg::*;

    logic intPending;
    logic pcErr;      // fetch from a misaligned pc
    logic isStore;
    logic eret;

    assign intPending = statusIe && !statusExl && |(statusIm & causeIp);
    assign pcErr      = |memPc[1:0];
    assign isStore    = memMemOp inside {opSb, opSh, opSw};
    assign eret       = memCp0Op == cp0Eret;

    always_comb begin
        if (intPending)
            excCode = excInt;
        else if (pcErr || (addrErr && !isStore))
            excCode = excAdel;
        else if (addrErr)
            excCode = excAdes;
        else
            excCode = excNone;   // eret lands here too
    end

    assign flushException  = (excCode != excNone) || eret;
    assign exceptionVector = (excCode == excNone) ? epc :
                             (statusBev ? `VEC_BOOT : `VEC_NORMAL);

endmodule

// ==== dataBusMaster.sv ====
module dataBusMaster (
    input  logic               clk,
    input  logic               arstN,
    input  logic               start,
    input  logic               isWrite,
    input  memStagePkg::word_t addr,
    input  memStagePkg::word_t wrData,
    input  logic [3:0]         wrStrb,
    output memStagePkg::word_t rdData,
    output logic               stall,
    output memStagePkg::word_t awaddr,
    output logic               awvalid,
    input  logic               awready,
    output memStagePkg::word_t wdata,
    output logic [3:0]         wstrb,
    output logic               wvalid,
    input  logic               wready,
    input  logic               bvalid,
    output logic               bready,
    output memStagePkg::word_t araddr,
    output logic               arvalid,
    input  logic               arready,
    input  memStagePkg::word_t rdata,
    input  logic               rvalid,
    output logic               rready
);
    import memStagePkg::*;

    busState_t state;
    logic      done;     // response seen, held instruction may leave
    logic      writeQ;
    logic      issue;
    word_t     addrQ;

    assign issue  = (state == busIdle) && start && !done;
    assign stall  = (state != busIdle) || (start && !done);
    assign awaddr = addrQ;
    assign araddr = addrQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= busIdle;
            done    <= 1'b0;
            writeQ  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
            bready  <= 1'b0;
            rready  <= 1'b0;
        end else begin
            case (state)
                busIdle: begin
                    done <= 1'b0;
                    if (issue) begin
                        writeQ  <= isWrite;
                        awvalid <= isWrite;   // aw and w raised together
                        wvalid  <= isWrite;
                        arvalid <= !isWrite;
                        state   <= busAddr;
                    end
                end
                busAddr: begin
                    if (awready)
                        awvalid <= 1'b0;
                    if (wready)
                        wvalid <= 1'b0;
                    if (arready)
                        arvalid <= 1'b0;
                    // aw and w may finish in different cycles
                    if (writeQ ? ((!awvalid || awready) && (!wvalid || wready)) : arready) begin
                        bready <= writeQ;
                        rready <= !writeQ;
                        state  <= busResp;
                    end
                end
                busResp: begin
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        bready <= 1'b0;
                        rready <= 1'b0;
                        done   <= 1'b1;
                        state  <= busIdle;
                    end
                end
                default: state <= busIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            addrQ <= addr;
            wdata <= wrData;
            wstrb <= wrStrb;
        end
        if (rvalid && rready)
            rdData <= rdata;   // read word kept for the done cycle
    end

    awHold: assert property (@(posedge clk) disable iff (!arstN)
        awvalid && !awready |=> awvalid && $stable(awaddr));
    wHold: assert property (@(posedge clk) disable iff (!arstN)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));
    arHold: assert property (@(posedge clk) disable iff (!arstN)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

// ==== memStage.sv ====
module memStage (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  memFlush,
    input  logic                  memWr,
    input  logic [5:0]            interrupt,
    input  memStagePkg::word_t    exeAluOut,
    input  memStagePkg::word_t    exeOutB,
    input  memStagePkg::word_t    exePc,
    input  memStagePkg::memOp_t   exeMemOp,
    input  memStagePkg::cp0Op_t   exeCp0Op,
    input  memStagePkg::regAddr_t exeCp0Rd,
    input  memStagePkg::regAddr_t exeDst,
    input  logic                  exeRegWr,
    output memStagePkg::word_t    memResult,   // forwarded result
    output memStagePkg::regAddr_t memDst,
    output logic                  memRegWr,
    output logic                  memStall,
    output logic                  flushException,
    output memStagePkg::word_t    exceptionVector,
    output memStagePkg::word_t    cp0Epc,
    output memStagePkg::word_t    awaddr,
    output logic                  awvalid,
    input  logic                  awready,
    output memStagePkg::word_t    wdata,
    output logic [3:0]            wstrb,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready,
    output memStagePkg::word_t    araddr,
    output logic                  arvalid,
    input  logic                  arready,
    input  memStagePkg::word_t    rdata,
    input  logic                  rvalid,
    output logic                  rready
);
    import memStagePkg::*;

    word_t    memAluOut;
    word_t    memOutB;
    word_t    memPc;
    memOp_t   memMemOp;
    cp0Op_t   memCp0Op;
    regAddr_t memCp0Rd;
    logic     regWrQ;        // before exception squash
    word_t    physAddr;
    logic     addrErr;
    word_t    badVAddr;
    word_t    busWdata;
    logic [3:0] busWstrb;
    word_t    readWord;
    word_t    loadData;
    word_t    cp0Rdata;
    logic     statusIe;
    logic     statusExl;
    logic     statusBev;
    logic [7:0] statusIm;
    logic [7:0] causeIp;
    excCode_t excCode;
    logic     isLoad;
    logic     isStore;

    assign isLoad   = memMemOp inside {opLb, opLbu, opLh, opLhu, opLw};
    assign isStore  = memMemOp inside {opSb, opSh, opSw};
    assign memRegWr = regWrQ && !flushException;
    assign badVAddr = (|memPc[1:0]) ? memPc : memAluOut;   // fetch error reports the pc

    always_comb begin
        if (memCp0Op == cp0Mfc0)
            memResult = cp0Rdata;
        else if (isLoad)
            memResult = loadData;
        else
            memResult = memAluOut;
    end

    memStageReg uMemStageReg (
        .clk       (clk),
        .arstN     (arstN),
        .flush     (memFlush),
        .wr        (memWr && !memStall),   // hold while the bus is busy
        .exeAluOut (exeAluOut),
        .exeOutB   (exeOutB),
        .exePc     (exePc),
        .exeMemOp  (exeMemOp),
        .exeCp0Op  (exeCp0Op),
        .exeCp0Rd  (exeCp0Rd),
        .exeDst    (exeDst),
        .exeRegWr  (exeRegWr),
        .memAluOut (memAluOut),
        .memOutB   (memOutB),
        .memPc     (memPc),
        .memMemOp  (memMemOp),
        .memCp0Op  (memCp0Op),
        .memCp0Rd  (memCp0Rd),
        .memDst    (memDst),
        .memRegWr  (regWrQ)
    );

    addrMap uAddrMap (
        .vaddr    (memAluOut),
        .memOp    (memMemOp),
        .physAddr (physAddr),
        .addrErr  (addrErr)
    );

    byteLaneAlign uByteLaneAlign (
        .memOp     (memMemOp),
        .addrLow   (memAluOut[1:0]),
        .storeData (memOutB),
        .loadWord  (readWord),
        .wdata     (busWdata),
        .wstrb     (busWstrb),
        .loadData  (loadData)
    );

    cp0Regs uCp0Regs (
        .clk       (clk),
        .arstN     (arstN),
        .interrupt (interrupt),
        .cp0Op     (memCp0Op),
        .rdSel     (memCp0Rd),
        .wdata     (memOutB),
        .commit    (!flushException && !memStall),
        .excTake   (flushException),
        .excCode   (excCode),
        .excPc     (memPc),
        .badVAddr  (badVAddr),
        .rdata     (cp0Rdata),
        .statusIe  (statusIe),
        .statusExl (statusExl),
        .statusBev (statusBev),
        .statusIm  (statusIm),
        .causeIp   (causeIp),
        .epc       (cp0Epc)
    );

    exceptionUnit uExceptionUnit (
        .memPc           (memPc),
        .addrErr         (addrErr),
        .memMemOp        (memMemOp),
        .memCp0Op        (memCp0Op),
        .statusIe        (statusIe),
        .statusExl       (statusExl),
        .statusBev       (statusBev),
        .statusIm        (statusIm),
        .causeIp         (causeIp),
        .epc             (cp0Epc),
        .flushException  (flushException),
        .excCode         (excCode),
        .exceptionVector (exceptionVector)
    );

    dataBusMaster uDataBusMaster (
        .clk     (clk),
        .arstN   (arstN),
        .start   ((isLoad || isStore) && !flushException),
        .isWrite (isStore),
        .addr    (physAddr),
        .wrData  (busWdata),
        .wrStrb  (busWstrb),
        .rdData  (readWord),
        .stall   (memStall),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

// ==== tbAxiRam.sv ====
module tbAxiRam (
    input  logic               clk,
    input  logic               arstN,
    input  memStagePkg::word_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  memStagePkg::word_t wdata,
    input  logic [3:0]         wstrb,
    input  logic               wvalid,
    output logic               wready,
    output logic               bvalid,
    input  logic               bready,
    input  memStagePkg::word_t araddr,
    input  logic               arvalid,
    output logic               arready,
    output memStagePkg::word_t rdata,
    output logic               rvalid,
    input  logic               rready
);
    timeunit 1ns;
    timeprecision 100ps;
    import memStagePkg::*;

    word_t       mem [64];
    logic [31:0] lfsr;
    logic [5:0]  awIdx;
    logic [5:0]  arIdx;
    word_t       wdQ;
    logic [3:0]  wsQ;
    logic        haveAw;
    logic        haveW;
    logic        haveAr;
    logic [1:0]  wDelay;    // cycles before bvalid
    logic [1:0]  rDelay;    // cycles before rvalid

    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always @(posedge clk or negedge arstN) begin : slave
        logic [31:0] s;
        logic [4:0]  bits;   // three readies, then a delay
        if (!arstN) begin
            for (int i = 0; i < 64; i++)
                mem[i] <= 32'h5a5a_0000 ^ (i * 32'h0101_0101);
            lfsr    <= 32'he72dfbd3;
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            haveAw  <= 1'b0;
            haveW   <= 1'b0;
            haveAr  <= 1'b0;
            wDelay  <= '0;
            rDelay  <= '0;
        end else begin
            s = lfsr;
            for (int k = 0; k < 5; k++) begin
                s = stepLfsr(s);
                bits[k] = s[0];
            end
            lfsr    <= s;
            awready <= bits[0];
            wready  <= bits[1];
            arready <= bits[2];
            if (awvalid && awready) begin
                awIdx  <= awaddr[7:2];
                haveAw <= 1'b1;
                wDelay <= bits[4:3];
            end
            if (wvalid && wready) begin
                wdQ   <= wdata;
                wsQ   <= wstrb;
                haveW <= 1'b1;
            end
            if (haveAw && haveW) begin
                if (wDelay == 2'd0) begin
                    for (int b = 0; b < 4; b++)
                        if (wsQ[b])
                            mem[awIdx][8*b +: 8] <= wdQ[8*b +: 8];
                    bvalid <= 1'b1;
                    haveAw <= 1'b0;
                    haveW  <= 1'b0;
                end else begin
                    wDelay <= wDelay - 2'd1;
                end
            end
            if (bvalid && bready)
                bvalid <= 1'b0;
            if (arvalid && arready) begin
                arIdx  <= araddr[7:2];
                haveAr <= 1'b1;
                rDelay <= bits[4:3];
            end
            if (haveAr) begin
                if (rDelay == 2'd0) begin
                    rdata  <= mem[arIdx];
                    rvalid <= 1'b1;
                    haveAr <= 1'b0;
                end else begin
                    rDelay <= rDelay - 2'd1;
                end
            end
            if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

endmodule

// ==== memStageTb.sv ====
`include "memStage_macros.svh"

module memStageTb;
    timeunit 1ns;
    timeprecision 100ps;
    import memStagePkg::*;

    localparam logic [1:0] chkValue  = 2'd0;   // fixed data or expected value
    localparam logic [1:0] chkShadow = 2'd1;   // random store data, load from shadow
    localparam logic [1:0] chkExc    = 2'd2;   // exception, vector in exp
    localparam logic [1:0] chkEret   = 2'd3;   // eret, epc in exp

    typedef struct packed {
        memOp_t     op;
        cp0Op_t     cop;
        regAddr_t   rd;
        word_t      addr;
        word_t      data;
        logic [5:0] intr;
        word_t      pc;
        logic [1:0] kind;
        word_t      exp;
    } row_t;

    logic clk;
    logic arstN;
    logic memFlush;
    logic memWr;
    logic [5:0] interrupt;
    word_t exeAluOut;
    word_t exeOutB;
    word_t exePc;
    memOp_t exeMemOp;
    cp0Op_t exeCp0Op;
    regAddr_t exeCp0Rd;
    regAddr_t exeDst;
    logic exeRegWr;
    word_t memResult;
    regAddr_t memDst;
    logic memRegWr;
    logic memStall;
    logic flushException;
    word_t exceptionVector;
    word_t cp0Epc;
    word_t awaddr;
    logic awvalid;
    logic awready;
    word_t wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    word_t araddr;
    logic arvalid;
    logic arready;
    word_t rdata;
    logic rvalid;
    logic rready;

    row_t        rows[$];
    word_t       shadow [64];
    logic [31:0] lfsr = 32'he72dfbd3;

    memStage uut (.*);

    tbAxiRam ram (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t nextWord();
        word_t w;
        w = '0;
        for (int k = 0; k < 32; k++) begin
            lfsr = lfsrStep(lfsr);
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    // lane pick and extension of the shadow word
    function automatic word_t expectLoad(input memOp_t op, input word_t addr);
        word_t w;
        w = shadow[addr[7:2]] >> (8 * int'(addr[1:0]));
        case (op)
            opLb:    return {{24{w[7]}}, w[7:0]};
            opLbu:   return {24'b0, w[7:0]};
            opLh:    return {{16{w[15]}}, w[15:0]};
            opLhu:   return {16'b0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic checkEq(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic addRow(input memOp_t op, input cp0Op_t cop, input regAddr_t rd,
                          input word_t addr, input word_t data, input logic [5:0] intr,
                          input word_t pc, input logic [1:0] kind, input word_t exp);
        rows.push_back('{op, cop, rd, addr, data, intr, pc, kind, exp});
    endtask

    task automatic driveBubble();
        exeMemOp  = opNone;
        exeCp0Op  = cp0None;
        exeCp0Rd  = '0;
        exeAluOut = '0;
        exeOutB   = '0;
        exePc     = '0;
        exeDst    = '0;
        exeRegWr  = 1'b0;
        interrupt = '0;
    endtask

    task automatic runRow(input row_t r);
        word_t data;
        int    lane;
        logic  store;
        store = r.op inside {opSb, opSh, opSw};
        data  = (store && r.kind == chkShadow) ? nextWord() : r.data;
        @(posedge clk);
        #2;
        exeMemOp  = r.op;
        exeCp0Op  = r.cop;
        exeCp0Rd  = r.rd;
        exeAluOut = r.addr;
        exeOutB   = data;
        exePc     = r.pc;
        exeDst    = r.pc[6:2];
        exeRegWr  = !store;
        interrupt = r.intr;
        @(posedge clk);   // row enters the stage
        #2;
        driveBubble();
        checkEq("memStall", {31'b0, memStall},
                {31'b0, (r.op != opNone) && (r.kind < chkExc)});
        while (memStall) begin
            @(posedge clk);
            #2;
        end
        checkEq("flushException", {31'b0, flushException}, {31'b0, r.kind >= chkExc});
        if (r.kind >= chkExc) begin
            checkEq("memRegWr", {31'b0, memRegWr}, 32'd0);
            if (r.kind == chkEret)
                checkEq("cp0Epc", cp0Epc, r.exp);
            checkEq("exceptionVector", exceptionVector, r.exp);
        end else if (store) begin
            lane = int'(r.addr[1:0]);
            if (r.op == opSb)
                shadow[r.addr[7:2]][8*lane +: 8] = data[7:0];
            else if (r.op == opSh)
                shadow[r.addr[7:2]][8*lane +: 16] = data[15:0];
            else
                shadow[r.addr[7:2]] = data;
        end else if (r.op != opNone) begin
            checkEq("memRegWr", {31'b0, memRegWr}, 32'd1);
            checkEq("memDst", {27'b0, memDst}, {27'b0, r.pc[6:2]});
            checkEq("memResult", memResult,
                    (r.kind == chkShadow) ? expectLoad(r.op, r.addr) : r.exp);
        end else begin
            checkEq("memRegWr", {31'b0, memRegWr}, 32'd1);
            checkEq("memDst", {27'b0, memDst}, {27'b0, r.pc[6:2]});
            checkEq("memResult", memResult, r.exp);
        end
    endtask

    // watchdog, ten cycles per row plus reset
    initial begin
        #1;
        #((rows.size() * 10 + 10) * 40);
        $display("Error: run timed out, memStall stayed high");
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        clk      = 1'b0;
        arstN    = 1'b0;
        memFlush = 1'b0;
        memWr    = 1'b1;
        driveBubble();
        for (int i = 0; i < 64; i++)
            shadow[i] = 32'h5a5a_0000 ^ (i * 32'h0101_0101);

        // translation and strobes, kseg0 and kseg1 alias the same word
        addRow(opSw, cp0None, 5'd0, 32'h8000_0010, 32'h1122_3344, 6'd0, 32'h8000_1000,
               chkValue, 32'h0);
        addRow(opLw, cp0None, 5'd0, 32'ha000_0010, 32'h0, 6'd0, 32'h8000_1004,
               chkValue, 32'h1122_3344);
        addRow(opSb, cp0None, 5'd0, 32'ha000_0011, 32'h0, 6'd0, 32'h8000_1008, chkShadow, 32'h0);
        addRow(opLw, cp0None, 5'd0, 32'h8000_0010, 32'h0, 6'd0, 32'h8000_100c, chkShadow, 32'h0);
        addRow(opSh, cp0None, 5'd0, 32'h8000_0012, 32'h0, 6'd0, 32'h8000_1010, chkShadow, 32'h0);
        addRow(opLw, cp0None, 5'd0, 32'ha000_0010, 32'h0, 6'd0, 32'h8000_1014, chkShadow, 32'h0);
        // extension of a known word
        addRow(opSw, cp0None, 5'd0, 32'h8000_0020, 32'h8a7b_f1c6, 6'd0, 32'h8000_1018,
               chkValue, 32'h0);
        addRow(opLb, cp0None, 5'd0, 32'h8000_0021, 32'h0, 6'd0, 32'h8000_101c,
               chkValue, 32'hffff_fff1);
        addRow(opLbu, cp0None, 5'd0, 32'ha000_0023, 32'h0, 6'd0, 32'h8000_1020,
               chkValue, 32'h0000_008a);
        addRow(opLh, cp0None, 5'd0, 32'h8000_0022, 32'h0, 6'd0, 32'h8000_1024,
               chkValue, 32'hffff_8a7b);
        addRow(opLhu, cp0None, 5'd0, 32'h8000_0020, 32'h0, 6'd0, 32'h8000_1028,
               chkValue, 32'h0000_f1c6);
        // address errors with BEV still set
        addRow(opLh, cp0None, 5'd0, 32'h8000_0031, 32'h0, 6'd0, 32'hbfc0_0100,
               chkExc, `VEC_BOOT);
        addRow(opNone, cp0Mfc0, `CP0_EPC, 32'h0, 32'h0, 6'd0, 32'h8000_102c,
               chkValue, 32'hbfc0_0100);
        addRow(opNone, cp0Mfc0, `CP0_BADVADDR, 32'h0, 32'h0, 6'd0, 32'h8000_1030,
               chkValue, 32'h8000_0031);
        addRow(opSw, cp0None, 5'd0, 32'h8000_0012, 32'hdead_beef, 6'd0, 32'h8000_1034,
               chkExc, `VEC_BOOT);
        addRow(opLw, cp0None, 5'd0, 32'h8000_0010, 32'h0, 6'd0, 32'h8000_1038, chkShadow, 32'h0);
        // clear BEV, set IE and IM2, then interrupt and eret
        addRow(opNone, cp0Mtc0, `CP0_STATUS, 32'h1357_9bdf, 32'h0000_0401, 6'd0, 32'h8000_103c,
               chkValue, 32'h1357_9bdf);
        addRow(opNone, cp0None, 5'd0, 32'h0, 32'h0, 6'd1, 32'h8000_0200, chkExc, `VEC_NORMAL);
        addRow(opNone, cp0Eret, 5'd0, 32'h0, 32'h0, 6'd0, 32'h8000_0204,
               chkEret, 32'h8000_0200);
        addRow(opNone, cp0Mfc0, `CP0_STATUS, 32'h0, 32'h0, 6'd0, 32'h8000_1040,
               chkValue, 32'h0000_0401);
        // random data under random slave timing
        addRow(opSw, cp0None, 5'd0, 32'h8000_0040, 32'h0, 6'd0, 32'h8000_1044, chkShadow, 32'h0);
        addRow(opLw, cp0None, 5'd0, 32'ha000_0040, 32'h0, 6'd0, 32'h8000_1048, chkShadow, 32'h0);
        addRow(opSb, cp0None, 5'd0, 32'h8000_0043, 32'h0, 6'd0, 32'h8000_104c, chkShadow, 32'h0);
        addRow(opLh, cp0None, 5'd0, 32'ha000_0042, 32'h0, 6'd0, 32'h8000_1050, chkShadow, 32'h0);
        addRow(opSh, cp0None, 5'd0, 32'ha000_0046, 32'h0, 6'd0, 32'h8000_1054, chkShadow, 32'h0);
        addRow(opLw, cp0None, 5'd0, 32'h8000_0044, 32'h0, 6'd0, 32'h8000_1058, chkShadow, 32'h0);
        addRow(opLbu, cp0None, 5'd0, 32'h8000_0045, 32'h0, 6'd0, 32'h8000_105c, chkShadow, 32'h0);
        addRow(opSb, cp0None, 5'd0, 32'ha000_0044, 32'h0, 6'd0, 32'h8000_1060, chkShadow, 32'h0);
        addRow(opLhu, cp0None, 5'd0, 32'h8000_0046, 32'h0, 6'd0, 32'h8000_1064, chkShadow, 32'h0);
        addRow(opLw, cp0None, 5'd0, 32'ha000_0010, 32'h0, 6'd0, 32'h8000_1068, chkShadow, 32'h0);

        repeat (3) @(posedge clk);
        #2;
        arstN = 1'b1;
        foreach (rows[i])
            runRow(rows[i]);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== memStage.f ====
+incdir+.
memStagePkg.sv
memStageReg.sv
byteLaneAlign.sv
addrMap.sv
cp0Regs.sv
exceptionUnit.sv
dataBusMaster.sv
memStage.sv
tbAxiRam.sv
memStageTb.sv

// ==== run.sh ====
#!/bin/bash
# builds and runs the testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f memStage.f --top-module memStageTb -o memStageSim &&
./obj_dir/memStageSim || exit 1
